//--- design/snn_bus_pkg.sv
package snn_bus_pkg;

    localparam int WB_WIDTH = 32;

    typedef logic [WB_WIDTH-1:0] wb_addr_t;
    typedef logic [WB_WIDTH-1:0] wb_data_t;

    // each region spans 4 KiB with one byte-wide entry per 32-bit word
    localparam int REGION_LSB = 12;

    localparam wb_addr_t IMAGE_BASE  = 32'h3000_0000;
    localparam wb_addr_t WEIGHT_BASE = 32'h3000_1000;
    localparam wb_addr_t COUNT_BASE  = 32'h3000_3000;
    localparam wb_addr_t CTRL_ADDR   = 32'h3000_4000;

    // control word layout
    localparam int CTRL_EN_BIT   = 28;
    localparam int TIMESTEPS_LSB = 16;
    localparam int VTH_LSB       = 8;
    localparam int BETA_LSB      = 0;

endpackage

//--- design/snn_net_pkg.sv
package snn_net_pkg;

    localparam int NUM_PIXELS  = 81;
    localparam int NUM_OUTPUTS = 10;
    localparam int NUM_WEIGHTS = NUM_PIXELS * NUM_OUTPUTS;

    typedef logic [7:0] pixel_t;
    typedef logic [7:0] weight_t;
    typedef logic [7:0] vmem_t;
    typedef logic [7:0] count_t;
    typedef logic [9:0] timestep_t;
    typedef logic [6:0] pixel_idx_t;
    typedef logic [3:0] out_idx_t;
    typedef logic [9:0] weight_addr_t;

    localparam timestep_t DEFAULT_TIMESTEPS = 10'd100;
    localparam pixel_t    LFSR_SEED         = 8'h5A;

    typedef enum logic [2:0] {
        IDLE,
        READ_PIXEL,
        ENCODE,
        POP_SPIKE,
        READ_WEIGHT,
        INTEGRATE,
        LEAK_FIRE,
        CHECK_END
    } ctrl_state_t;

endpackage

//--- design/snn_frame_mem.sv
`timescale 1ns/1ps

module snn_frame_mem #(
    parameter int DEPTH = snn_net_pkg::NUM_PIXELS
) (
    input  logic                     clk,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  snn_net_pkg::pixel_t      wdata_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_i,
    output snn_net_pkg::pixel_t      rdata_o
);
    import snn_net_pkg::*;

    pixel_t mem [DEPTH];

    // write port and registered read port
    always_ff @(posedge clk)
    begin
        if (we_i)
            mem[waddr_i] <= wdata_i;
        rdata_o <= mem[raddr_i];
    end

endmodule

//--- design/snn_spike_queue.sv
`timescale 1ns/1ps

module snn_spike_queue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    push_i,
    input  snn_net_pkg::pixel_idx_t din_i,
    input  logic                    pop_i,
    output logic                    valid_o,
    output snn_net_pkg::pixel_idx_t dout_o
);
    import snn_net_pkg::*;

    localparam int CNT_W = $clog2(NUM_PIXELS + 1);

    pixel_idx_t       fifo [NUM_PIXELS];
    pixel_idx_t       wr_ptr;
    pixel_idx_t       rd_ptr;
    logic [CNT_W-1:0] occupancy;

    // pointers wrap after the last pixel slot
    function automatic pixel_idx_t next_ptr(input pixel_idx_t ptr);
        return (ptr == pixel_idx_t'(NUM_PIXELS - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk)
    begin
        if (push_i)
            fifo[wr_ptr] <= din_i;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end
        else
        begin
            if (push_i)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop_i)
                rd_ptr <= next_ptr(rd_ptr);
            if (push_i && !pop_i)
                occupancy <= occupancy + 1'b1;
            else if (pop_i && !push_i)
                occupancy <= occupancy - 1'b1;
        end
    end

    assign valid_o = occupancy != '0;
    assign dout_o  = fifo[rd_ptr];

endmodule

//--- design/snn_neuron_array.sv
`timescale 1ns/1ps

module snn_neuron_array (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clear_i,
    input  logic                  integrate_i,
    input  logic                  leak_fire_i,
    input  snn_net_pkg::out_idx_t neuron_idx_i,
    input  snn_net_pkg::weight_t  weight_i,
    input  snn_net_pkg::vmem_t    beta_i,
    input  snn_net_pkg::vmem_t    vth_i,
    input  snn_net_pkg::out_idx_t count_idx_i,
    output snn_net_pkg::count_t   count_o
);
    import snn_net_pkg::*;

    vmem_t       vmem [NUM_OUTPUTS];
    count_t      spikes [NUM_OUTPUTS];
    vmem_t       v_sel;
    logic [8:0]  sum;
    logic [15:0] product;

    // arithmetic on the selected neuron only
    always_comb
    begin
        v_sel   = vmem[neuron_idx_i];
        sum     = 9'(v_sel) + 9'(weight_i);
        product = 16'(v_sel) * 16'(beta_i);
    end

    always_ff @(posedge clk)
    begin
        if (rst || clear_i)
        begin
            for (int i = 0; i < NUM_OUTPUTS; i++)
            begin
                vmem[i]   <= '0;
                spikes[i] <= '0;
            end
        end
        else if (integrate_i)
            // saturate at full scale
            vmem[neuron_idx_i] <= sum[8] ? '1 : sum[7:0];
        else if (leak_fire_i)
        begin
            if (v_sel >= vth_i)
            begin
                vmem[neuron_idx_i]   <= '0;
                spikes[neuron_idx_i] <= spikes[neuron_idx_i] + 1'b1;
            end
            else
                vmem[neuron_idx_i] <= product[15:8];
        end
    end

    assign count_o = (count_idx_i < NUM_OUTPUTS) ? spikes[count_idx_i] : '0;

endmodule

//--- design/snn_controller.sv
`timescale 1ns/1ps

module snn_controller (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      infer_en_i,
    input  snn_net_pkg::timestep_t    timesteps_i,
    output snn_net_pkg::pixel_idx_t   image_raddr_o,
    input  snn_net_pkg::pixel_t       image_rdata_i,
    output snn_net_pkg::weight_addr_t weight_raddr_o,
    input  snn_net_pkg::weight_t      weight_rdata_i,
    output logic                      q_push_o,
    output snn_net_pkg::pixel_idx_t   q_din_o,
    output logic                      q_pop_o,
    input  logic                      q_valid_i,
    input  snn_net_pkg::pixel_idx_t   q_dout_i,
    output logic                      clear_o,
    output logic                      integrate_o,
    output logic                      leak_fire_o,
    output snn_net_pkg::out_idx_t     neuron_idx_o,
    output logic                      done_o
);
    import snn_net_pkg::*;

    ctrl_state_t state;
    pixel_idx_t  pix_idx;
    pixel_idx_t  spike_idx;
    out_idx_t    out_idx;
    timestep_t   step;
    pixel_t      lfsr;
    logic        last_pixel;
    logic        last_output;
    logic        last_step;

    assign last_pixel  = pix_idx == pixel_idx_t'(NUM_PIXELS - 1);
    assign last_output = out_idx == out_idx_t'(NUM_OUTPUTS - 1);
    assign last_step   = timestep_t'(step + 1'b1) == timesteps_i;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= IDLE;
            lfsr    <= LFSR_SEED;
            pix_idx <= '0;
            out_idx <= '0;
            step    <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (infer_en_i)
                    begin
                        lfsr    <= LFSR_SEED;
                        pix_idx <= '0;
                        out_idx <= '0;
                        step    <= '0;
                        state   <= READ_PIXEL;
                    end
                READ_PIXEL:
                    state <= ENCODE;
                ENCODE:
                begin
                    // taps 8,6,5,4
                    lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
                    pix_idx <= last_pixel ? '0 : pix_idx + 1'b1;
                    state   <= last_pixel ? POP_SPIKE : READ_PIXEL;
                end
                POP_SPIKE:
                    if (q_valid_i)
                    begin
                        spike_idx <= q_dout_i;
                        state     <= READ_WEIGHT;
                    end
                    else
                        state <= LEAK_FIRE;
                READ_WEIGHT:
                    state <= INTEGRATE;
                INTEGRATE:
                begin
                    out_idx <= last_output ? '0 : out_idx + 1'b1;
                    state   <= last_output ? POP_SPIKE : READ_WEIGHT;
                end
                LEAK_FIRE:
                begin
                    out_idx <= last_output ? '0 : out_idx + 1'b1;
                    state   <= last_output ? CHECK_END : LEAK_FIRE;
                end
                CHECK_END:
                begin
                    step  <= step + 1'b1;
                    state <= last_step ? IDLE : READ_PIXEL;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    assign image_raddr_o  = pix_idx;
    // row of ten weights per input pixel
    assign weight_raddr_o = weight_addr_t'(spike_idx) * weight_addr_t'(NUM_OUTPUTS)
                          + weight_addr_t'(out_idx);

    assign q_push_o = (state == ENCODE) && (lfsr < image_rdata_i);
    assign q_din_o  = pix_idx;
    assign q_pop_o  = (state == POP_SPIKE) && q_valid_i;

    assign clear_o      = (state == IDLE) && infer_en_i;
    // a zero weight leaves the potential as it is
    assign integrate_o  = (state == INTEGRATE) && (weight_rdata_i != '0);
    assign leak_fire_o  = state == LEAK_FIRE;
    assign neuron_idx_o = out_idx;
    assign done_o       = (state == CHECK_END) && last_step;

endmodule

//--- design/snn_wb_regs.sv
`timescale 1ns/1ps

module snn_wb_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  snn_bus_pkg::wb_addr_t    wb_adr_i,
    input  snn_bus_pkg::wb_data_t    wb_dat_i,
    output logic                     wb_ack_o,
    output snn_bus_pkg::wb_data_t    wb_dat_o,
    input  logic                     done_i,
    input  snn_net_pkg::count_t      count_i,
    output snn_net_pkg::out_idx_t    count_idx_o,
    output logic                     image_we_o,
    output snn_net_pkg::pixel_idx_t  image_waddr_o,
    output logic                     weight_we_o,
    output snn_net_pkg::weight_addr_t weight_waddr_o,
    output snn_net_pkg::pixel_t      wdata_o,
    output logic                     infer_en_o,
    output snn_net_pkg::vmem_t       beta_o,
    output snn_net_pkg::vmem_t       vth_o,
    output snn_net_pkg::timestep_t   timesteps_o,
    output logic                     irq_o
);
    import snn_bus_pkg::*;
    import snn_net_pkg::*;

    logic                  req;
    logic                  in_image;
    logic                  in_weight;
    logic                  in_count;
    logic                  in_ctrl;
    logic [REGION_LSB-3:0] entry;
    wb_data_t              rdata;

    // new request only while no ack is pending
    assign req       = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign entry     = wb_adr_i[REGION_LSB-1:2];
    assign in_image  = wb_adr_i[WB_WIDTH-1:REGION_LSB] == IMAGE_BASE[WB_WIDTH-1:REGION_LSB];
    assign in_weight = wb_adr_i[WB_WIDTH-1:REGION_LSB] == WEIGHT_BASE[WB_WIDTH-1:REGION_LSB];
    assign in_count  = wb_adr_i[WB_WIDTH-1:REGION_LSB] == COUNT_BASE[WB_WIDTH-1:REGION_LSB];
    assign in_ctrl   = wb_adr_i == CTRL_ADDR;

    assign count_idx_o = out_idx_t'(entry);

    // unmapped reads return zero
    always_comb
    begin
        rdata = '0;
        if (in_count && entry < NUM_OUTPUTS)
            rdata[$bits(count_t)-1:0] = count_i;
        else if (in_ctrl)
        begin
            rdata[CTRL_EN_BIT]                          = infer_en_o;
            rdata[TIMESTEPS_LSB +: $bits(timestep_t)]   = timesteps_o;
            rdata[VTH_LSB +: $bits(vmem_t)]             = vth_o;
            rdata[BETA_LSB +: $bits(vmem_t)]            = beta_o;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wb_ack_o    <= 1'b0;
            image_we_o  <= 1'b0;
            weight_we_o <= 1'b0;
            infer_en_o  <= 1'b0;
            beta_o      <= '0;
            vth_o       <= '0;
            timesteps_o <= DEFAULT_TIMESTEPS;
            irq_o       <= 1'b0;
        end
        else
        begin
            wb_ack_o    <= req;
            image_we_o  <= req && wb_we_i && in_image && (entry < NUM_PIXELS);
            weight_we_o <= req && wb_we_i && in_weight && (entry < NUM_WEIGHTS);
            if (req && wb_we_i && in_ctrl)
            begin
                irq_o <= 1'b0;
                // fields are frozen while a run is active
                if (!infer_en_o)
                begin
                    infer_en_o  <= wb_dat_i[CTRL_EN_BIT];
                    timesteps_o <= wb_dat_i[TIMESTEPS_LSB +: $bits(timestep_t)];
                    vth_o       <= wb_dat_i[VTH_LSB +: $bits(vmem_t)];
                    beta_o      <= wb_dat_i[BETA_LSB +: $bits(vmem_t)];
                end
            end
            if (done_i)
            begin
                infer_en_o <= 1'b0;
                irq_o      <= 1'b1;
            end
        end
    end

    // write payload and read data captured on each request
    always_ff @(posedge clk)
    begin
        if (req)
        begin
            image_waddr_o  <= pixel_idx_t'(entry);
            weight_waddr_o <= entry;
            wdata_o        <= wb_dat_i[$bits(pixel_t)-1:0];
            wb_dat_o       <= rdata;
        end
    end

endmodule

//--- design/snn_top.sv
`timescale 1ns/1ps

module snn_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  snn_bus_pkg::wb_addr_t wb_adr_i,
    input  snn_bus_pkg::wb_data_t wb_dat_i,
    output logic                  wb_ack_o,
    output snn_bus_pkg::wb_data_t wb_dat_o,
    output logic                  irq_o
);
    import snn_net_pkg::*;

    logic         done;
    count_t       count;
    out_idx_t     count_idx;
    logic         image_we;
    pixel_idx_t   image_waddr;
    logic         weight_we;
    weight_addr_t weight_waddr;
    pixel_t       wdata;
    logic         infer_en;
    vmem_t        beta;
    vmem_t        vth;
    timestep_t    timesteps;
    pixel_idx_t   image_raddr;
    pixel_t       image_rdata;
    weight_addr_t weight_raddr;
    weight_t      weight_rdata;
    logic         q_push;
    pixel_idx_t   q_din;
    logic         q_pop;
    logic         q_valid;
    pixel_idx_t   q_dout;
    logic         clear;
    logic         integrate;
    logic         leak_fire;
    out_idx_t     neuron_idx;

    snn_wb_regs regs_i (
        .clk(clk), .rst(rst),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
        .wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o),
        .done_i(done), .count_i(count), .count_idx_o(count_idx),
        .image_we_o(image_we), .image_waddr_o(image_waddr),
        .weight_we_o(weight_we), .weight_waddr_o(weight_waddr),
        .wdata_o(wdata), .infer_en_o(infer_en), .beta_o(beta), .vth_o(vth),
        .timesteps_o(timesteps), .irq_o(irq_o)
    );

    snn_frame_mem #(.DEPTH(NUM_PIXELS)) image_mem (
        .clk(clk), .we_i(image_we), .waddr_i(image_waddr), .wdata_i(wdata),
        .raddr_i(image_raddr), .rdata_o(image_rdata)
    );

    snn_frame_mem #(.DEPTH(NUM_WEIGHTS)) weight_mem (
        .clk(clk), .we_i(weight_we), .waddr_i(weight_waddr), .wdata_i(wdata),
        .raddr_i(weight_raddr), .rdata_o(weight_rdata)
    );

    snn_spike_queue queue_i (
        .clk(clk), .rst(rst), .push_i(q_push), .din_i(q_din),
        .pop_i(q_pop), .valid_o(q_valid), .dout_o(q_dout)
    );

    snn_neuron_array neurons_i (
        .clk(clk), .rst(rst), .clear_i(clear), .integrate_i(integrate),
        .leak_fire_i(leak_fire), .neuron_idx_i(neuron_idx), .weight_i(weight_rdata),
        .beta_i(beta), .vth_i(vth), .count_idx_i(count_idx), .count_o(count)
    );

    snn_controller ctrl_i (
        .clk(clk), .rst(rst), .infer_en_i(infer_en), .timesteps_i(timesteps),
        .image_raddr_o(image_raddr), .image_rdata_i(image_rdata),
        .weight_raddr_o(weight_raddr), .weight_rdata_i(weight_rdata),
        .q_push_o(q_push), .q_din_o(q_din), .q_pop_o(q_pop),
        .q_valid_i(q_valid), .q_dout_i(q_dout),
        .clear_o(clear), .integrate_o(integrate), .leak_fire_o(leak_fire),
        .neuron_idx_o(neuron_idx), .done_o(done)
    );

endmodule

//--- testbench/snn_checker.sv
`timescale 1ns/1ps

module snn_checker (
    input logic                  clk,
    input logic                  rst,
    input logic                  cyc_i,
    input logic                  stb_i,
    input logic                  we_i,
    input snn_bus_pkg::wb_addr_t adr_i,
    input logic                  ack_i,
    input logic                  irq_i
);
    import snn_bus_pkg::*;

    logic ctrl_write;

    // a new control write request as the slave sees it
    assign ctrl_write = cyc_i && stb_i && we_i && !ack_i && (adr_i == CTRL_ADDR);

    ack_single: assert property (@(posedge clk) disable iff (rst) ack_i |=> !ack_i)
        else $error("ack high for two cycles in a row");

    ack_after_req: assert property (@(posedge clk) disable iff (rst)
        ack_i |-> $past(cyc_i && stb_i))
        else $error("ack without a preceding cyc and stb");

    irq_sticky: assert property (@(posedge clk) disable iff (rst)
        irq_i && !ctrl_write |=> irq_i)
        else $error("irq dropped without a control write");

endmodule

//--- testbench/snn_ref_model.svh
// reference model of one inference run
// reads image_data and weight_data and fills exp_counts
function automatic void compute_expected_counts(input int steps, input int vth, input int beta);
    int lfsr;
    int feedback;
    int acc;
    int v [NUM_OUTPUTS];
    int spiking [$];
    lfsr = LFSR_SEED;
    for (int o = 0; o < NUM_OUTPUTS; o++)
    begin
        v[o] = 0;
        exp_counts[o] = 0;
    end
    for (int t = 0; t < steps; t++)
    begin
        spiking.delete();
        // compare with the current value, then advance once per pixel
        for (int p = 0; p < NUM_PIXELS; p++)
        begin
            if (lfsr < image_data[p])
                spiking.push_back(p);
            feedback = ((lfsr >> 7) ^ (lfsr >> 5) ^ (lfsr >> 4) ^ (lfsr >> 3)) & 1;
            lfsr = ((lfsr << 1) | feedback) & 255;
        end
        // integrate every spike into all outputs
        foreach (spiking[s])
        begin
            for (int o = 0; o < NUM_OUTPUTS; o++)
            begin
                acc = v[o] + weight_data[spiking[s] * NUM_OUTPUTS + o];
                v[o] = (acc > 255) ? 255 : acc;
            end
        end
        // fire or leak
        for (int o = 0; o < NUM_OUTPUTS; o++)
        begin
            if (v[o] >= vth)
            begin
                v[o] = 0;
                exp_counts[o] = (exp_counts[o] + 1) & 255;
            end
            else
                v[o] = (v[o] * beta) >> 8;
        end
    end
endfunction

//--- testbench/tb_snn.sv
`timescale 1ns/1ps

module tb_snn;
    import snn_bus_pkg::*;
    import snn_net_pkg::*;

    localparam int ACK_TIMEOUT = 16;
    localparam int IRQ_TIMEOUT = 2000000;
    localparam int NUM_RUNS    = 4;

    logic     clk;
    logic     rst;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    logic     wb_ack;
    wb_data_t wb_dat_r;
    logic     irq;

    integer seed;
    int     image_data [NUM_PIXELS];
    int     weight_data [NUM_WEIGHTS];
    int     exp_counts [NUM_OUTPUTS];

    `include "snn_ref_model.svh"

    snn_top snn_top_i (
        .clk(clk), .rst(rst),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
        .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
        .wb_ack_o(wb_ack), .wb_dat_o(wb_dat_r), .irq_o(irq)
    );

    bind snn_top snn_checker checker_i (
        .clk(clk), .rst(rst), .cyc_i(wb_cyc_i), .stb_i(wb_stb_i), .we_i(wb_we_i),
        .adr_i(wb_adr_i), .ack_i(wb_ack_o), .irq_i(irq_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
            abort_run("value mismatch");
        end
    endtask

    function automatic int random_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    function automatic wb_data_t make_ctrl(input int en, input int ts, input int vth,
                                           input int beta);
        wb_data_t word;
        word = '0;
        word[CTRL_EN_BIT] = en[0];
        word[TIMESTEPS_LSB +: 10] = ts[9:0];
        word[VTH_LSB +: 8] = vth[7:0];
        word[BETA_LSB +: 8] = beta[7:0];
        return word;
    endfunction

    // single access, then stb drops right after ack is seen
    task automatic bus_access(input logic we, input wb_addr_t addr, input wb_data_t wdata,
                              output wb_data_t rdata);
        int waited;
        @(posedge clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = addr;
        wb_dat_w = wdata;
        waited = 0;
        while (!wb_ack)
        begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > ACK_TIMEOUT)
                abort_run("bus access was never acknowledged");
        end
        // ack comes exactly one cycle after the request
        check_equal("wb_ack_o latency", waited, 1);
        rdata = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic bus_write(input wb_addr_t addr, input wb_data_t data);
        wb_data_t unused;
        bus_access(1'b1, addr, data, unused);
    endtask

    task automatic bus_read(input wb_addr_t addr, output wb_data_t data);
        bus_access(1'b0, addr, '0, data);
    endtask

    task automatic wait_for_irq();
        int cycles;
        cycles = 0;
        while (!irq)
        begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > IRQ_TIMEOUT)
                abort_run("timed out waiting for the interrupt");
        end
    endtask

    task automatic load_memories();
        for (int p = 0; p < NUM_PIXELS; p++)
            bus_write(IMAGE_BASE + wb_addr_t'(4 * p), wb_data_t'(image_data[p]));
        for (int i = 0; i < NUM_WEIGHTS; i++)
            bus_write(WEIGHT_BASE + wb_addr_t'(4 * i), wb_data_t'(weight_data[i]));
    endtask

    task automatic run_and_check(input int steps, input int vth, input int beta);
        wb_data_t rd;
        compute_expected_counts(steps, vth, beta);
        bus_write(CTRL_ADDR, make_ctrl(1, steps, vth, beta));
        check_equal("irq_o", irq, 0);
        // the first fire comes well over a hundred cycles after the start
        for (int o = 0; o < NUM_OUTPUTS; o++)
        begin
            bus_read(COUNT_BASE + wb_addr_t'(4 * o), rd);
            check_equal($sformatf("count[%0d] after start", o), rd, 0);
        end
        wait_for_irq();
        bus_read(CTRL_ADDR, rd);
        check_equal("ctrl_en", rd[CTRL_EN_BIT], 0);
        for (int o = 0; o < NUM_OUTPUTS; o++)
        begin
            bus_read(COUNT_BASE + wb_addr_t'(4 * o), rd);
            check_equal($sformatf("count[%0d]", o), rd, exp_counts[o]);
        end
    endtask

    initial
    begin
        wb_data_t rd;
        int       steps;
        int       vth;
        int       beta;
        seed = 32'hd00a_a7aa;
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        // reset values and an unmapped read
        check_equal("irq_o", irq, 0);
        bus_read(CTRL_ADDR, rd);
        check_equal("ctrl", rd, make_ctrl(0, 100, 0, 0));
        bus_read(32'h3000_2000, rd);
        check_equal("unmapped", rd, 0);

        // control fields read back while idle
        steps = $random(seed) & 1023;
        vth = random_below(256);
        beta = random_below(256);
        bus_write(CTRL_ADDR, make_ctrl(0, steps, vth, beta));
        bus_read(CTRL_ADDR, rd);
        check_equal("ctrl", rd, make_ctrl(0, steps, vth, beta));

        // dark image never spikes, and a nonzero threshold is never reached
        for (int p = 0; p < NUM_PIXELS; p++)
            image_data[p] = 0;
        for (int i = 0; i < NUM_WEIGHTS; i++)
            weight_data[i] = random_below(256);
        load_memories();
        run_and_check(1 + random_below(20), 1 + random_below(255), random_below(256));
        for (int o = 0; o < NUM_OUTPUTS; o++)
        begin
            bus_read(COUNT_BASE + wb_addr_t'(4 * o), rd);
            check_equal($sformatf("count[%0d]", o), rd, 0);
        end

        // random runs
        for (int r = 0; r < NUM_RUNS; r++)
        begin
            for (int p = 0; p < NUM_PIXELS; p++)
                image_data[p] = random_below(256);
            for (int i = 0; i < NUM_WEIGHTS; i++)
                weight_data[i] = random_below(256);
            load_memories();
            steps = 1 + random_below(20);
            vth = random_below(256);
            beta = random_below(256);
            run_and_check(steps, vth, beta);
        end

        // full scale image and weights
        for (int p = 0; p < NUM_PIXELS; p++)
            image_data[p] = 255;
        for (int i = 0; i < NUM_WEIGHTS; i++)
            weight_data[i] = 255;
        load_memories();
        run_and_check(1 + random_below(20), 1, random_below(256));

        // restart over the same data while every count is nonzero
        check_equal("irq_o", irq, 1);
        run_and_check(1 + random_below(20), 1, random_below(256));

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+testbench
design/snn_bus_pkg.sv
design/snn_net_pkg.sv
design/snn_frame_mem.sv
design/snn_spike_queue.sv
design/snn_neuron_array.sv
design/snn_controller.sv
design/snn_wb_regs.sv
design/snn_top.sv
testbench/snn_checker.sv
testbench/tb_snn.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_snn \
    -f sources.f -o sim_snn &&
./obj_dir/sim_snn ||
{ echo "simulation failed"; exit 1; }
